// File: Makefile
# Verilator build and run of the RV32I core testbench

TOP       ?= tb_rv_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build folder and the log"
	@echo "Overridable: TOP FILELIST OBJ_DIR LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/instr_exec.sv
`timescale 1ns/1ns

module instr_exec (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::exec_op_t  ex_op,
    output rv_pkg::wb_t       wb,
    output rv_pkg::redirect_t redirect,
    output rv_pkg::retire_t   retire
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_res;
    logic          br_cond;                    // Branch condition holds

    assign op_a = ex_op.rs1_data;
    assign op_b = ex_op.use_imm ? ex_op.imm : ex_op.rs2_data;

    ////////////////////////////////////////
    // ALU
    always_comb begin
        case (ex_op.alu_op)
            rv_pkg::alu_add:    alu_res = op_a + op_b;
            rv_pkg::alu_sub:    alu_res = op_a - op_b;
            rv_pkg::alu_sll:    alu_res = op_a << op_b[4:0];   // Low 5 bits are shamt
            rv_pkg::alu_slt:    alu_res = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::alu_sltu:   alu_res = rv_pkg::word_t'(op_a < op_b);
            rv_pkg::alu_xor:    alu_res = op_a ^ op_b;
            rv_pkg::alu_srl:    alu_res = op_a >> op_b[4:0];
            rv_pkg::alu_sra:    alu_res = rv_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            rv_pkg::alu_or:     alu_res = op_a | op_b;
            rv_pkg::alu_and:    alu_res = op_a & op_b;
            default:            alu_res = op_b;                // LUI
        endcase
    end

    ////////////////////////////////////////
    // Branch resolution
    always_comb begin
        case (ex_op.br_f3)
            rv_pkg::f3_beq:  br_cond = ex_op.rs1_data == ex_op.rs2_data;
            rv_pkg::f3_bne:  br_cond = ex_op.rs1_data != ex_op.rs2_data;
            rv_pkg::f3_blt:  br_cond = $signed(ex_op.rs1_data) < $signed(ex_op.rs2_data);
            rv_pkg::f3_bge:  br_cond = $signed(ex_op.rs1_data) >= $signed(ex_op.rs2_data);
            rv_pkg::f3_bltu: br_cond = ex_op.rs1_data < ex_op.rs2_data;
            rv_pkg::f3_bgeu: br_cond = ex_op.rs1_data >= ex_op.rs2_data;
            default:         br_cond = 1'b0;           // Reserved codes fall through
        endcase
    end

    // Target is pc relative
    assign redirect.taken  = ex_op.valid && ex_op.is_branch && br_cond;
    assign redirect.target = ex_op.pc + ex_op.imm;

    // Writeback and bypass source
    assign wb.enable = ex_op.valid && ex_op.wr_rd;
    assign wb.rd     = ex_op.rd;
    assign wb.data   = alu_res;

    ////////////////////////////////////////
    // Retire record, one per register write
    always_ff @(posedge clk) begin
        retire.valid   <= wb.enable;
        retire.pc      <= ex_op.pc;
        retire.rd      <= wb.rd;
        retire.rd_data <= wb.data;
        if (reset) begin
            retire.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/instr_fetch_decode.sv
`timescale 1ns/1ns

module instr_fetch_decode (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::instr_t      instr,        // Answer for current pc
    input  rv_pkg::redirect_t   redirect,     // From execute
    output rv_pkg::word_t       pc,
    output logic                instr_rd_en,
    output rv_pkg::decoded_op_t dec_op
);

    rv_pkg::opcode_t     opcode;
    rv_pkg::decoded_op_t dec_next;
    logic                supported;           // Opcode is one we execute

    assign opcode = instr.r.opcode;           // Same bits in every format

    // funct3 plus alt bit to ALU op
    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_t op;
        case (f3)
            rv_pkg::f3_add:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:  op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:  op = rv_pkg::alu_slt;
            rv_pkg::f3_sltu: op = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:  op = rv_pkg::alu_xor;
            rv_pkg::f3_sr:   op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:   op = rv_pkg::alu_or;
            default:         op = rv_pkg::alu_and;  // f3_and
        endcase
        return op;
    endfunction

    ////////////////////////////////////////
    // Program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= rv_pkg::reset_pc;
            instr_rd_en <= 1'b0;
        end else begin
            instr_rd_en <= 1'b1;
            if (redirect.taken) begin
                pc <= redirect.target;                // Taken branch wins
            end else if (instr_rd_en) begin
                pc <= pc + rv_pkg::word_t'(4);
            end
        end
    end

    ////////////////////////////////////////
    // Decode
    always_comb begin
        dec_next        = '0;
        dec_next.pc     = pc;
        dec_next.alu_op = rv_pkg::alu_add;
        supported       = 1'b1;
        case (opcode)
            rv_pkg::opc_op: begin
                dec_next.rs1    = instr.r.rs1;
                dec_next.rs2    = instr.r.rs2;
                dec_next.rd     = instr.r.rd;
                dec_next.alu_op = alu_sel(instr.r.funct3, instr.r.funct7 == rv_pkg::f7_alt);
                dec_next.wr_rd  = 1'b1;
            end
            rv_pkg::opc_op_imm: begin
                dec_next.rs1     = instr.i.rs1;
                dec_next.rd      = instr.i.rd;
                dec_next.imm     = {{20{instr.i.imm[11]}}, instr.i.imm};  // Sign extend
                dec_next.use_imm = 1'b1;
                // Only SRAI takes the alt bit, ADDI has no subtract form
                dec_next.alu_op  = alu_sel(instr.i.funct3,
                                           instr.i.funct3 == rv_pkg::f3_sr && instr.i.imm[10]);
                dec_next.wr_rd   = 1'b1;
            end
            rv_pkg::opc_lui: begin
                dec_next.rd      = instr.u.rd;
                dec_next.imm     = {instr.u.imm, 12'h000};
                dec_next.use_imm = 1'b1;
                dec_next.alu_op  = rv_pkg::alu_pass_b;  // Result is the immediate
                dec_next.wr_rd   = 1'b1;
            end
            rv_pkg::opc_branch: begin
                dec_next.rs1       = instr.b.rs1;
                dec_next.rs2       = instr.b.rs2;
                dec_next.imm       = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                                      instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                dec_next.is_branch = 1'b1;
                dec_next.br_f3     = instr.b.funct3;
            end
            default: supported = 1'b0;         // Anything else is a bubble
        endcase
        // A write to x0 is no write at all
        if (dec_next.rd == '0) begin
            dec_next.wr_rd = 1'b0;
        end
        dec_next.valid = instr_rd_en && supported && !redirect.taken;  // Squash on redirect
    end

    always_ff @(posedge clk) begin
        dec_op <= dec_next;
        if (reset) begin
            dec_op.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/operand_fetch.sv
`timescale 1ns/1ns

module operand_fetch (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::decoded_op_t dec_op,
    input  rv_pkg::wb_t         wb,        // Register write and bypass source
    input  rv_pkg::redirect_t   redirect,
    output rv_pkg::exec_op_t    ex_op
);

    rv_pkg::word_t    regs [0:(1 << rv_pkg::reg_addr_w)-1];  // x0 slot never read
    rv_pkg::word_t    rs1_val;
    rv_pkg::word_t    rs2_val;
    rv_pkg::exec_op_t ex_next;

    // Source read with x0 and bypass handling
    function automatic rv_pkg::word_t read_src(
        input rv_pkg::reg_addr_t idx,
        input rv_pkg::word_t     stored,
        input rv_pkg::wb_t       w
    );
        rv_pkg::word_t val;
        if (idx == '0) begin
            val = '0;                                  // x0 reads zero
        end else if (w.enable && w.rd == idx) begin
            val = w.data;                              // Result from execute this cycle
        end else begin
            val = stored;
        end
        return val;
    endfunction

    ////////////////////////////////////////
    // Register file
    always_ff @(posedge clk) begin
        if (wb.enable && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_val = read_src(dec_op.rs1, regs[dec_op.rs1], wb);
    assign rs2_val = read_src(dec_op.rs2, regs[dec_op.rs2], wb);

    ////////////////////////////////////////
    // Execute op register
    always_comb begin
        ex_next.valid     = dec_op.valid && !redirect.taken;  // Younger op squashed
        ex_next.pc        = dec_op.pc;
        ex_next.rs1_data  = rs1_val;
        ex_next.rs2_data  = rs2_val;
        ex_next.rd        = dec_op.rd;
        ex_next.imm       = dec_op.imm;
        ex_next.alu_op    = dec_op.alu_op;
        ex_next.use_imm   = dec_op.use_imm;
        ex_next.is_branch = dec_op.is_branch;
        ex_next.br_f3     = dec_op.br_f3;
        ex_next.wr_rd     = dec_op.wr_rd;
    end

    always_ff @(posedge clk) begin
        ex_op <= ex_next;
        if (reset) begin
            ex_op.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ns

module rv_core (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::instr_t  instr,        // Instruction for pc, same cycle
    output rv_pkg::word_t   pc,
    output logic            instr_rd_en,
    output rv_pkg::retire_t retire        // One record per register write
);

    rv_pkg::decoded_op_t dec_op;          // Fetch and decode to operand stage
    rv_pkg::exec_op_t    ex_op;           // Operand stage to execute
    rv_pkg::wb_t         wb;              // Register write and bypass
    rv_pkg::redirect_t   redirect;        // Taken branch

    ////////////////////////////////////////
    // Fetch and decode
    instr_fetch_decode instr_fetch_decode_inst (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .redirect    (redirect),
        .pc          (pc),
        .instr_rd_en (instr_rd_en),
        .dec_op      (dec_op)
    );

    // Operand fetch with register file
    operand_fetch operand_fetch_inst (
        .clk      (clk),
        .reset    (reset),
        .dec_op   (dec_op),
        .wb       (wb),
        .redirect (redirect),
        .ex_op    (ex_op)
    );

    // Execute and writeback
    instr_exec instr_exec_inst (
        .clk      (clk),
        .reset    (reset),
        .ex_op    (ex_op),
        .wb       (wb),
        .redirect (redirect),
        .retire   (retire)
    );

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////
    // Widths and reset vector
    localparam int          xlen       = 32;
    localparam int          reg_addr_w = 5;
    localparam logic [31:0] reset_pc   = 32'h0000_0000;  // First fetch address

    ////////////////////////////////////////
    // Opcodes kept by this core
    localparam logic [6:0] opc_op     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] opc_op_imm = 7'b0010011;  // Immediate ALU
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // ALU funct3
    localparam logic [2:0] f3_add  = 3'b000;  // ADD / SUB
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // SRL / SRA
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_alt = 7'b0100000;  // Selects SUB and SRA

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;

    ////////////////////////////////////////
    // Instruction formats, all 32 bits
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;     // Sign bit at 11, shamt in [4:0]
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;     // Upper 20 bits of the result
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm12;    // Sign bit
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
        b_fmt_t b;
        word_t  raw;
    } instr_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    ////////////////////////////////////////
    // Stage records
    typedef struct packed {
        logic       valid;
        word_t      pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      imm;
        alu_op_t    alu_op;
        logic       use_imm;    // Operand b from imm
        logic       is_branch;
        logic [2:0] br_f3;      // Branch condition
        logic       wr_rd;      // Writes a nonzero rd
    } decoded_op_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        reg_addr_t  rd;
        word_t      imm;
        alu_op_t    alu_op;
        logic       use_imm;
        logic       is_branch;
        logic [2:0] br_f3;
        logic       wr_rd;
    } exec_op_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      enable;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     rd_data;
    } retire_t;

endpackage

// File: list.f
hdl/rv_pkg.sv
hdl/instr_fetch_decode.sv
hdl/operand_fetch.sv
hdl/instr_exec.sv
hdl/rv_core.sv
test/rv_core_assert.sv
test/tb_rv_core.sv

// File: test/rv_core_assert.sv
`timescale 1ns/1ns

module rv_core_assert (
    input logic              clk,
    input logic              reset,
    input rv_pkg::word_t     pc,
    input logic              instr_rd_en,
    input rv_pkg::retire_t   retire,
    input rv_pkg::redirect_t redirect      // Internal to rv_core
);

    // Retire register cleared by reset
    retire_quiet: assert property (@(posedge clk) reset |=> !retire.valid)
        else $error("retire.valid high in the cycle after a reset edge");

    // Fetch runs every cycle out of reset
    fetch_on: assert property (@(posedge clk) !reset |=> instr_rd_en)
        else $error("instr_rd_en low after reset ended");

    x0_clean: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && retire.rd == '0) |-> retire.rd_data == '0)
        else $error("retire to x0 with nonzero data");

    // Taken branch steers the next fetch
    redirect_pc: assert property (@(posedge clk) disable iff (reset)
        redirect.taken |=> pc == $past(redirect.target))
        else $error("pc does not match the branch target after a redirect");

endmodule

bind rv_core rv_core_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .instr_rd_en (instr_rd_en),
    .retire      (retire),
    .redirect    (redirect)
);

// File: test/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

    logic            clk;
    logic            reset;
    rv_pkg::instr_t  instr;
    rv_pkg::word_t   pc;
    logic            instr_rd_en;
    rv_pkg::retire_t retire;

    rv_pkg::instr_t  imem [0:255];         // Word addressed program
    int              prog_len;
    rv_pkg::instr_t  prog_q [$];           // Program being built
    rv_pkg::retire_t exp_q [$];            // Model records
    rv_pkg::retire_t got_q [$];            // DUT records, in order
    rv_pkg::word_t   mregs [0:31];         // Model register file kept across tests
    int              errors;
    int              checks;
    int              tests;
    int              test_errs;
    int              cycle;
    int              cycle_limit = 2000;   // About 150 ops in six programs at 2*len+30 each

    rv_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .pc          (pc),
        .instr_rd_en (instr_rd_en),
        .retire      (retire)
    );

    ////////////////////////////////////////
    // Clock, memory, monitor, timeout
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        if (pc < rv_pkg::word_t'(prog_len * 4)) begin
            instr <= imem[pc[9:2]];
        end else begin
            instr <= '0;                   // Opcode 0 is a bubble
        end
    end

    always @(posedge clk) begin
        if (retire.valid === 1'b1) begin
            got_q.push_back(retire);       // Pre-edge value of the retire register
        end
    end

    initial begin
        cycle = 0;
        while (cycle < cycle_limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Instruction builders
    task automatic reg_op(input logic [2:0] f3, input logic alt,
                          input rv_pkg::reg_addr_t rd, rs1, rs2);
        rv_pkg::instr_t ins;
        ins.raw = {alt ? rv_pkg::f7_alt : 7'h00, rs2, rs1, f3, rd, rv_pkg::opc_op};
        prog_q.push_back(ins);
    endtask

    task automatic imm_op(input logic [2:0] f3, input rv_pkg::reg_addr_t rd, rs1,
                          input logic [11:0] imm);
        rv_pkg::instr_t ins;
        ins.raw = {imm, rs1, f3, rd, rv_pkg::opc_op_imm};
        prog_q.push_back(ins);
    endtask

    task automatic lui_op(input rv_pkg::reg_addr_t rd, input logic [19:0] imm);
        rv_pkg::instr_t ins;
        ins.raw = {imm, rd, rv_pkg::opc_lui};
        prog_q.push_back(ins);
    endtask

    // Branch by 12 over two shadow ops to a target op
    task automatic branch_group(input logic [2:0] f3, input rv_pkg::reg_addr_t rs1, rs2);
        rv_pkg::instr_t ins;
        ins.raw = {1'b0, 6'd0, rs2, rs1, f3, 4'd6, 1'b0, rv_pkg::opc_branch};
        prog_q.push_back(ins);
        imm_op(rv_pkg::f3_add, 28, 28, 12'd1);   // Shadow
        imm_op(rv_pkg::f3_add, 29, 29, 12'd1);   // Shadow
        imm_op(rv_pkg::f3_add, 30, 30, 12'd1);   // Target
    endtask

    ////////////////////////////////////////
    // ISA reference model
    function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, b);
        rv_pkg::word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];   // Arithmetic
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic taken_ref(input logic [2:0] f3, input rv_pkg::word_t a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic run_model();
        rv_pkg::instr_t  ins;
        rv_pkg::retire_t rec;
        rv_pkg::word_t   res;
        rv_pkg::word_t   boff;
        logic            writes;
        int              idx;
        int              steps;
        idx = 0;
        steps = 0;
        exp_q.delete();
        while (idx >= 0 && idx < prog_q.size() && steps < 256) begin
            ins = prog_q[idx];
            writes = 1'b1;
            res = '0;
            case (ins.r.opcode)
                rv_pkg::opc_op: res = alu_ref(ins.r.funct3, ins.r.funct7[5],
                                              mregs[ins.r.rs1], mregs[ins.r.rs2]);
                rv_pkg::opc_op_imm: res = alu_ref(ins.i.funct3,
                                                  ins.i.funct3 == 3'b101 && ins.i.imm[10],
                                                  mregs[ins.i.rs1],
                                                  {{20{ins.i.imm[11]}}, ins.i.imm});
                rv_pkg::opc_lui: res = {ins.u.imm, 12'h000};
                default: writes = 1'b0;          // Branch or bubble
            endcase
            if (writes && ins.r.rd != 5'd0) begin
                mregs[ins.r.rd] = res;
                rec.valid = 1'b1;
                rec.pc = rv_pkg::reset_pc + rv_pkg::word_t'(idx * 4);
                rec.rd = ins.r.rd;
                rec.rd_data = res;
                exp_q.push_back(rec);
            end
            if (ins.r.opcode == rv_pkg::opc_branch &&
                taken_ref(ins.b.funct3, mregs[ins.b.rs1], mregs[ins.b.rs2])) begin
                boff = {{20{ins.b.imm12}}, ins.b.imm11, ins.b.imm10_5, ins.b.imm4_1, 1'b0};
                idx = idx + ($signed(boff) >>> 2);
            end else begin
                idx++;
            end
            steps++;
        end
    endtask

    ////////////////////////////////////////
    // Checks and reporting
    task automatic flag_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errs++;
    endtask

    task automatic compare_retire(input string name, input rv_pkg::retire_t exp,
                                  input rv_pkg::retire_t act);
        checks++;
        if (act.pc !== exp.pc || act.rd !== exp.rd || act.rd_data !== exp.rd_data) begin
            flag_error($sformatf("ERR %s: expected pc %h x%0d=%h, actual pc %h x%0d=%h",
                                 name, exp.pc, exp.rd, exp.rd_data,
                                 act.pc, act.rd, act.rd_data));
        end
    endtask

    task automatic compare_word(input string name, input rv_pkg::word_t exp,
                                input rv_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            flag_error($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // Hold reset, load program, run model, release
    task automatic start_program();
        @(posedge clk);
        #1 reset = 1'b1;
        @(posedge clk);
        #1;
        foreach (prog_q[k]) begin
            imem[k] = prog_q[k];
        end
        prog_len = prog_q.size();
        run_model();
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        got_q.delete();
        test_errs = 0;
    endtask

    task automatic finish_program(input string name);
        int waited;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < 2 * prog_len + 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (4) begin                          // Room for a stray retirement
            @(posedge clk);
            #1;
        end
        if (got_q.size() != exp_q.size()) begin
            flag_error($sformatf("%s: expected %0d retirements, the DUT gave %0d",
                                 name, exp_q.size(), got_q.size()));
        end
        foreach (exp_q[k]) begin
            if (k < got_q.size()) begin
                compare_retire(name, exp_q[k], got_q[k]);
            end
        end
        tests++;
        $display("%-14s %0d records, %0d errors", name, exp_q.size(), test_errs);
    endtask

    ////////////////////////////////////////
    // Directed tests
    task automatic reset_check();
        int r;
        prog_q.delete();
        for (r = 1; r < 32; r++) begin
            imm_op(rv_pkg::f3_add, 5'(r), 0, 12'(r * 37 - 500));  // Fills every register
        end
        start_program();
        compare_word("reset", rv_pkg::reset_pc, pc);
        // Fetch starts one edge after release and the first retire comes three edges later
        for (r = 0; r < 4; r++) begin
            checks++;
            if (instr_rd_en !== (r != 0)) begin
                flag_error($sformatf("ERR reset: expected instr_rd_en %b, actual %b",
                                     r != 0, instr_rd_en));
            end
            if (retire.valid !== 1'b0) begin
                flag_error($sformatf("reset: retirement %0d cycles after reset", r));
            end
            @(posedge clk);
            #1;
        end
        if (retire.valid !== 1'b1) begin
            flag_error("reset: first instruction did not retire after 3 stages");
        end
        finish_program("reset");
    endtask

    task automatic imm_alu();
        prog_q.delete();
        imm_op(rv_pkg::f3_add, 1, 0, 12'hffb);    // -5
        imm_op(rv_pkg::f3_add, 2, 1, 12'd100);    // 95
        imm_op(rv_pkg::f3_slt, 3, 1, 12'hffc);
        imm_op(rv_pkg::f3_slt, 4, 2, 12'hfff);
        imm_op(rv_pkg::f3_sltu, 5, 1, 12'hfff);   // Compared unsigned
        imm_op(rv_pkg::f3_sltu, 6, 2, 12'd10);
        imm_op(rv_pkg::f3_xor, 7, 1, 12'hfff);    // NOT
        imm_op(rv_pkg::f3_or, 8, 2, 12'h8f0);
        imm_op(rv_pkg::f3_and, 9, 1, 12'hff0);
        imm_op(rv_pkg::f3_sll, 10, 2, 12'd7);
        imm_op(rv_pkg::f3_sr, 11, 1, 12'h004);    // SRLI
        imm_op(rv_pkg::f3_sr, 12, 1, 12'h404);    // SRAI
        start_program();
        finish_program("imm_alu");
    endtask

    // Each op reads the one before it
    task automatic reg_alu_bypass();
        prog_q.delete();
        reg_op(rv_pkg::f3_add, 0, 13, 1, 2);
        reg_op(rv_pkg::f3_add, 1, 14, 13, 1);     // SUB
        reg_op(rv_pkg::f3_sll, 0, 15, 14, 3);
        reg_op(rv_pkg::f3_slt, 0, 16, 1, 15);
        reg_op(rv_pkg::f3_sltu, 0, 17, 16, 1);
        reg_op(rv_pkg::f3_xor, 0, 18, 17, 7);
        reg_op(rv_pkg::f3_sr, 0, 19, 18, 10);     // SRL
        reg_op(rv_pkg::f3_sr, 1, 20, 19, 5);      // SRA
        reg_op(rv_pkg::f3_or, 0, 21, 20, 18);
        reg_op(rv_pkg::f3_and, 0, 22, 21, 20);
        start_program();
        finish_program("reg_alu");
    endtask

    task automatic lui_and_x0();
        prog_q.delete();
        lui_op(23, 20'habcde);
        lui_op(24, 20'h80000);
        imm_op(rv_pkg::f3_add, 0, 23, 12'd5);     // Dropped write to x0
        lui_op(0, 20'h12345);
        reg_op(rv_pkg::f3_add, 0, 25, 0, 23);     // x0 right after a write to it
        reg_op(rv_pkg::f3_or, 0, 26, 0, 0);
        reg_op(rv_pkg::f3_add, 0, 27, 24, 0);
        start_program();
        finish_program("lui_x0");
    endtask

    // Sources x1 = -5 and x2 = 95 with the first of each pair taken
    task automatic branches();
        prog_q.delete();
        branch_group(rv_pkg::f3_beq, 1, 1);
        branch_group(rv_pkg::f3_beq, 1, 2);
        branch_group(rv_pkg::f3_bne, 1, 2);
        branch_group(rv_pkg::f3_bne, 1, 1);
        branch_group(rv_pkg::f3_blt, 1, 2);
        branch_group(rv_pkg::f3_blt, 2, 1);
        branch_group(rv_pkg::f3_bge, 2, 1);
        branch_group(rv_pkg::f3_bge, 1, 2);
        branch_group(rv_pkg::f3_bltu, 2, 1);
        branch_group(rv_pkg::f3_bltu, 1, 2);
        branch_group(rv_pkg::f3_bgeu, 1, 2);
        branch_group(rv_pkg::f3_bgeu, 2, 1);
        start_program();
        finish_program("branches");
    endtask

    task automatic random_ops();
        int                 n;
        int                 kind;
        logic [2:0]         f3;
        logic [11:0]        imm;
        rv_pkg::reg_addr_t  rd;
        rv_pkg::reg_addr_t  rs1;
        rv_pkg::reg_addr_t  rs2;
        prog_q.delete();
        for (n = 0; n < 40; n++) begin
            rd = 5'($urandom_range(31, 0));
            rs1 = 5'($urandom_range(31, 0));
            rs2 = 5'($urandom_range(31, 0));
            f3 = 3'($urandom_range(7, 0));
            kind = $urandom_range(2, 0);
            if (kind == 0) begin
                reg_op(f3, (f3 == rv_pkg::f3_add || f3 == rv_pkg::f3_sr) &&
                           $urandom_range(1, 0) == 1, rd, rs1, rs2);
            end else if (kind == 1) begin
                imm = 12'($urandom);
                if (f3 == rv_pkg::f3_sll) begin
                    imm[11:5] = 7'd0;
                end else if (f3 == rv_pkg::f3_sr) begin
                    imm[11:5] = {1'b0, imm[10], 5'd0};   // SRLI or SRAI
                end
                imm_op(f3, rd, rs1, imm);
            end else begin
                lui_op(rd, 20'($urandom));
            end
        end
        start_program();
        finish_program("random");
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(32'hfde));
        reset = 1'b1;
        instr = '0;
        prog_len = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errs = 0;
        mregs[0] = '0;
        reset_check();                   // Also fills x1..x31
        imm_alu();
        reg_alu_bypass();
        lui_and_x0();
        branches();
        random_ops();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
